// File: src/osc_pkg.sv
package osc_pkg;

  // ##########################################################################
  // widths
  // ##########################################################################

  localparam int cntr_width     = 10; // sample counter and buffer address.
  localparam int sample_width   = 16;
  localparam int apb_addr_width = 13;
  localparam int align_bits     = 6;  // trigger address is rounded down to 64 samples.
  localparam int buf_depth      = 1 << cntr_width;

  // ##########################################################################
  // APB register map
  // ##########################################################################

  localparam logic [apb_addr_width-1:0] reg_ctrl   = 13'h000;
  localparam logic [apb_addr_width-1:0] reg_pre    = 13'h004;
  localparam logic [apb_addr_width-1:0] reg_tot    = 13'h008;
  localparam logic [apb_addr_width-1:0] reg_level  = 13'h00C;
  localparam logic [apb_addr_width-1:0] reg_status = 13'h010;
  localparam logic [apb_addr_width-1:0] buf_base   = 13'h1000;

  localparam int ctrl_run       = 0; // write pulse.
  localparam int ctrl_soft_trig = 1; // write pulse.
  localparam int ctrl_falling   = 2; // stored edge select.

  // both channels of one sample with ch_a in the low half.
  typedef struct packed {
    logic signed [sample_width-1:0] ch_b;
    logic signed [sample_width-1:0] ch_a;
  } osc_sample_t;

  typedef struct packed {
    logic [cntr_width-1:0] addr;
    logic                  enbl;
  } osc_status_t;

  typedef struct packed {
    logic        [cntr_width-1:0]   pre_count;
    logic        [cntr_width-1:0]   tot_count;
    logic signed [sample_width-1:0] trig_level;
    logic                           falling;
  } osc_cfg_t;

endpackage

// File: src/osc_trigger.sv
`timescale 1ns/1ns

module osc_trigger
  import osc_pkg::*;
(
  input  logic        aclk,
  input  logic        aresetn,
  input  osc_cfg_t    cfg,
  input  osc_sample_t s_sample,
  input  logic        s_valid,
  input  logic        soft_trig,
  output logic        trg
);

  logic signed [sample_width-1:0] prev_a;
  logic                           prev_ok;
  logic                           soft_pend;
  logic                           cross_up;
  logic                           cross_dn;
  logic                           level_hit;

  // channel A of the last valid sample.
  always_ff @(posedge aclk)
  begin
    if (s_valid)
      prev_a <= s_sample.ch_a;
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      prev_ok   <= 1'b0;
      soft_pend <= 1'b0;
    end
    else
    begin
      if (s_valid)
        prev_ok <= 1'b1;
      if (s_valid)
        soft_pend <= 1'b0; // consumed by this sample.
      else if (soft_trig)
        soft_pend <= 1'b1;
    end
  end

  assign cross_up  = (prev_a < cfg.trig_level) && (s_sample.ch_a >= cfg.trig_level);
  assign cross_dn  = (prev_a >= cfg.trig_level) && (s_sample.ch_a < cfg.trig_level);
  assign level_hit = prev_ok && (cfg.falling ? cross_dn : cross_up);

  assign trg = s_valid && (level_hit || soft_pend || soft_trig);

endmodule

// File: src/osc_capture.sv
`timescale 1ns/1ns

module osc_capture
  import osc_pkg::*;
(
  input  logic        aclk,
  input  logic        aresetn,
  input  osc_cfg_t    cfg,
  input  logic        run,
  input  logic        trg,
  input  osc_sample_t s_sample,
  input  logic        s_valid,
  output osc_sample_t m_sample,
  output logic        m_valid,
  output osc_status_t status
);

  typedef enum logic [1:0] {
    st_idle,
    st_pre_fill,
    st_armed,
    st_post_fill
  } cap_state_t;

  cap_state_t            state, state_next;
  logic [cntr_width-1:0] addr, addr_next;
  logic [cntr_width-1:0] cntr, cntr_next;
  logic                  enbl, enbl_next;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      state <= st_idle;
      addr  <= '0;
      cntr  <= '0;
      enbl  <= 1'b0;
    end
    else
    begin
      state <= state_next;
      addr  <= addr_next;
      cntr  <= cntr_next;
      enbl  <= enbl_next;
    end
  end

  always_comb
  begin
    state_next = state;
    addr_next  = addr;
    cntr_next  = cntr;
    enbl_next  = enbl;

    case (state)
      st_idle:
      begin
        if (run)
        begin
          addr_next  = '0;
          cntr_next  = '0;
          enbl_next  = 1'b1;
          state_next = st_pre_fill;
        end
      end

      st_pre_fill:
      begin
        if (s_valid)
        begin
          cntr_next = cntr + 1'b1;
          if (cntr == cfg.pre_count)
            state_next = st_armed;
        end
      end

      st_armed:
      begin
        if (s_valid)
        begin
          cntr_next = cntr + 1'b1;
          if (trg)
          begin
            // the window keeps the offset of the trigger inside its 64-sample block.
            addr_next  = {cntr[cntr_width-1:align_bits], {align_bits{1'b0}}};
            cntr_next  = cfg.pre_count + cntr[align_bits-1:0];
            state_next = st_post_fill;
          end
        end
      end

      st_post_fill:
      begin
        if (s_valid)
        begin
          if (cntr < cfg.tot_count)
            cntr_next = cntr + 1'b1;
          else
          begin
            enbl_next  = 1'b0; // last sample is still written.
            state_next = st_idle;
          end
        end
      end

      default: state_next = st_idle;
    endcase
  end

  assign m_sample    = s_sample;
  assign m_valid     = enbl & s_valid;
  assign status.addr = addr;
  assign status.enbl = enbl;

endmodule

// File: src/osc_ring_buffer.sv
`timescale 1ns/1ns

module osc_ring_buffer
  import osc_pkg::*;
(
  input  logic                  aclk,
  input  logic                  aresetn,
  input  logic                  run,
  input  logic                  wr_valid,
  input  osc_sample_t           wr_sample,
  input  logic [cntr_width-1:0] rd_addr,
  output osc_sample_t           rd_data
);

  // ##########################################################################
  // write pointer
  // ##########################################################################

  logic [cntr_width-1:0] wr_ptr;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
      wr_ptr <= '0;
    else if (run)
      wr_ptr <= '0;
    else if (wr_valid)
      wr_ptr <= wr_ptr + 1'b1; // wraps at buf_depth.
  end

  // ##########################################################################
  // sample memory
  // ##########################################################################

  osc_sample_t mem [buf_depth];

  always_ff @(posedge aclk)
  begin
    if (wr_valid)
      mem[wr_ptr] <= wr_sample;
  end

  // read data follows the address by one cycle.
  always_ff @(posedge aclk)
  begin
    rd_data <= mem[rd_addr];
  end

endmodule

// File: src/osc_apb_regs.sv
`timescale 1ns/1ns

module osc_apb_regs
  import osc_pkg::*;
(
  input  logic                      aclk,
  input  logic                      aresetn,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [apb_addr_width-1:0] paddr,
  input  logic [31:0]               pwdata,
  output logic [31:0]               prdata,
  output logic                      pready,
  output logic                      pslverr,
  input  osc_status_t               status,
  input  osc_sample_t               rd_data,
  output osc_cfg_t                  cfg,
  output logic                      run,
  output logic                      soft_trig,
  output logic [cntr_width-1:0]     rd_addr
);

  logic        in_buf;
  logic        hit_ctrl;
  logic        hit_pre;
  logic        hit_tot;
  logic        hit_level;
  logic        hit_status;
  logic        mapped;
  logic        buf_rd;
  logic        rd_wait;
  logic        access;
  logic        wr_en;
  logic [31:0] reg_rdata;

  // ##########################################################################
  // decode and handshake
  // ##########################################################################

  assign in_buf     = paddr >= buf_base;
  assign hit_ctrl   = paddr == reg_ctrl;
  assign hit_pre    = paddr == reg_pre;
  assign hit_tot    = paddr == reg_tot;
  assign hit_level  = paddr == reg_level;
  assign hit_status = paddr == reg_status;
  assign mapped     = in_buf | hit_ctrl | hit_pre | hit_tot | hit_level | hit_status;

  assign buf_rd  = in_buf & ~pwrite; // buffer writes are ignored.
  assign rd_addr = paddr[cntr_width+1:2]; // valid from the setup phase on.

  // buffer reads wait one cycle, everything else completes at once.
  assign pready  = psel & penable & (~buf_rd | rd_wait);
  assign pslverr = psel & penable & ~mapped;
  assign access  = psel & penable & pready;
  assign wr_en   = access & pwrite & mapped;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
      rd_wait <= 1'b0;
    else
      rd_wait <= psel & penable & buf_rd & ~rd_wait;
  end

  // ##########################################################################
  // configuration and pulses
  // ##########################################################################

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      cfg       <= '0;
      run       <= 1'b0;
      soft_trig <= 1'b0;
    end
    else
    begin
      run       <= wr_en & hit_ctrl & pwdata[ctrl_run];
      soft_trig <= wr_en & hit_ctrl & pwdata[ctrl_soft_trig];
      if (wr_en && hit_ctrl)
        cfg.falling <= pwdata[ctrl_falling];
      if (wr_en && hit_pre)
        cfg.pre_count <= pwdata[cntr_width-1:0];
      if (wr_en && hit_tot)
        cfg.tot_count <= pwdata[cntr_width-1:0];
      if (wr_en && hit_level)
        cfg.trig_level <= pwdata[sample_width-1:0];
    end
  end

  // ##########################################################################
  // read data
  // ##########################################################################

  always_comb
  begin
    reg_rdata = '0;
    if (hit_ctrl)
      reg_rdata[ctrl_falling] = cfg.falling; // pulse bits read as zero.
    else if (hit_pre)
      reg_rdata[cntr_width-1:0] = cfg.pre_count;
    else if (hit_tot)
      reg_rdata[cntr_width-1:0] = cfg.tot_count;
    else if (hit_level)
      reg_rdata = {{(32-sample_width){cfg.trig_level[sample_width-1]}}, cfg.trig_level};
    else if (hit_status)
      reg_rdata[$bits(osc_status_t)-1:0] = status;
  end

  assign prdata = in_buf ? rd_data : reg_rdata;

endmodule

// File: src/osc_top.sv
`timescale 1ns/1ns

module osc_top
  import osc_pkg::*;
(
  input  logic                      aclk,
  input  logic                      aresetn,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [apb_addr_width-1:0] paddr,
  input  logic [31:0]               pwdata,
  output logic [31:0]               prdata,
  output logic                      pready,
  output logic                      pslverr,
  input  osc_sample_t               s_sample,
  input  logic                      s_valid,
  output osc_sample_t               m_sample,
  output logic                      m_valid
);

  osc_cfg_t              cfg;
  osc_status_t           status;
  osc_sample_t           rd_data;
  logic [cntr_width-1:0] rd_addr;
  logic                  run;
  logic                  soft_trig;
  logic                  trg;

  osc_apb_regs u_apb_regs (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .status    (status),
    .rd_data   (rd_data),
    .cfg       (cfg),
    .run       (run),
    .soft_trig (soft_trig),
    .rd_addr   (rd_addr)
  );

  osc_trigger u_trigger (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .cfg       (cfg),
    .s_sample  (s_sample),
    .s_valid   (s_valid),
    .soft_trig (soft_trig),
    .trg       (trg)
  );

  osc_capture u_capture (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .cfg      (cfg),
    .run      (run),
    .trg      (trg),
    .s_sample (s_sample),
    .s_valid  (s_valid),
    .m_sample (m_sample),
    .m_valid  (m_valid),
    .status   (status)
  );

  // the gated stream is what lands in the buffer.
  osc_ring_buffer u_ring_buffer (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .run       (run),
    .wr_valid  (m_valid),
    .wr_sample (m_sample),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

endmodule

// File: verif/osc_tb.sv
`timescale 1ns/1ns

module osc_tb
  import osc_pkg::*;
();

  localparam int num_rows = 5;

  // k is the sample index that must trigger in this capture scenario.
  typedef struct packed {
    logic        [cntr_width-1:0]   pre_count;
    logic        [cntr_width-1:0]   tot_count;
    logic signed [sample_width-1:0] level;
    logic                           falling;
    logic                           use_soft;
    logic        [cntr_width-1:0]   k;
    logic        [cntr_width-1:0]   spike; // index of an early crossing in pre-fill or 0 for none.
  } row_t;

  logic                      aclk;
  logic                      aresetn;
  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  logic [apb_addr_width-1:0] paddr;
  logic [31:0]               pwdata;
  logic [31:0]               prdata;
  logic                      pready;
  logic                      pslverr;
  osc_sample_t               s_sample;
  logic                      s_valid;
  osc_sample_t               m_sample;
  logic                      m_valid;

  row_t rows [num_rows];
  int   cycles       = 0;
  int   cycle_limit  = 0;
  int   mv_count     = 0;
  int   test_err     = 0;
  int   tests_run    = 0;
  int   tests_failed = 0;

  osc_top dut (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .s_sample (s_sample),
    .s_valid  (s_valid),
    .m_sample (m_sample),
    .m_valid  (m_valid)
  );

  initial
  begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  always @(posedge aclk)
  begin
    cycles = cycles + 1;
    if (cycles > cycle_limit)
    begin
      $display("ERROR: the run did not finish within %0d clock cycles.", cycle_limit);
      $display("Regression failed");
      $finish;
    end
  end

  // ##########################################################################
  // expected values
  // ##########################################################################

  // channel A ramps by 16 per sample and crosses the level only at sample k.
  function automatic logic signed [sample_width-1:0] ch_a_value(input row_t r, input int n);
    int a;
    a = 16 * (n - int'(r.k)) + 8;
    if (r.falling)
      a = -a;
    if (!r.use_soft)
      a = a + int'(r.level);
    if (r.spike != 0 && n == int'(r.spike))
      a = int'(r.level) - 100; // dips below the level for one sample.
    return a[sample_width-1:0];
  endfunction

  function automatic int expected_count(input row_t r);
    return int'(r.k) + 2 + int'(r.tot_count) - int'(r.pre_count) - (int'(r.k) % 64);
  endfunction

  // ##########################################################################
  // reporting and bus tasks
  // ##########################################################################

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("FAIL at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    test_err++;
  endtask

  task automatic close_test(input string name);
    tests_run++;
    if (test_err == 0)
      $display("test %s: ok", name);
    else
    begin
      $display("test %s: %0d errors", name, test_err);
      tests_failed++;
    end
    test_err = 0;
  endtask

  // entered and left 2 ns after a rising edge.
  task automatic apb_access(input logic wr, input logic [apb_addr_width-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int waits;
    int exp_waits;
    waits     = 0;
    exp_waits = (!wr && addr >= buf_base) ? 1 : 0; // only buffer reads take a wait state.
    psel      = 1'b1;
    penable   = 1'b0;
    pwrite    = wr;
    paddr     = addr;
    pwdata    = wdata;
    @(posedge aclk);
    #2;
    penable = 1'b1;
    @(negedge aclk);
    while (!pready && waits < 8)
    begin
      @(negedge aclk);
      waits++;
    end
    if (!pready)
    begin
      $display("ERROR: the APB access to address %h never completed.", addr);
      test_err++;
    end
    else if (waits != exp_waits)
      report_mismatch("pready wait cycles", waits, exp_waits);
    rdata = prdata;
    err   = pslverr;
    @(posedge aclk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic drive_sample(input row_t r, input int n);
    int gap;
    gap = $urandom % 4;
    repeat (gap)
    begin
      @(posedge aclk);
      #2;
    end
    s_sample.ch_b = n[sample_width-1:0];
    s_sample.ch_a = ch_a_value(r, n);
    s_valid       = 1'b1;
    @(posedge aclk);
    #2;
    s_valid = 1'b0;
  endtask

  // the gated stream must carry samples 0, 1, 2 ... in order.
  always @(negedge aclk)
  begin
    if (m_valid)
    begin
      if (m_sample.ch_b !== mv_count[sample_width-1:0])
        report_mismatch("m_sample.ch_b", {16'h0, m_sample.ch_b}, mv_count);
      mv_count = mv_count + 1;
    end
  end

  task automatic run_capture(input int idx);
    row_t                      r;
    int                        n_exp;
    int                        probe [3];
    logic [apb_addr_width-1:0] a;
    logic [31:0]               rd;
    logic                      err;
    r        = rows[idx];
    n_exp    = expected_count(r);
    probe[0] = 0;
    probe[1] = int'(r.k) % buf_depth;
    probe[2] = (n_exp - 1) % buf_depth;
    apb_access(1'b1, reg_pre, {22'h0, r.pre_count}, rd, err);
    apb_access(1'b1, reg_tot, {22'h0, r.tot_count}, rd, err);
    apb_access(1'b1, reg_level, {16'h0, r.level}, rd, err);
    mv_count = 0;
    apb_access(1'b1, reg_ctrl, {29'h0, r.falling, 2'b01}, rd, err);
    apb_access(1'b0, reg_status, 32'h0, rd, err);
    if (rd !== 32'h1)
      report_mismatch("status after run", rd, 32'h1);
    // four extra samples must be dropped once capture has ended.
    for (int n = 0; n < n_exp + 4; n++)
    begin
      if (r.use_soft && n == int'(r.k))
        apb_access(1'b1, reg_ctrl, {29'h0, r.falling, 2'b10}, rd, err);
      drive_sample(r, n);
    end
    repeat (2)
    begin
      @(posedge aclk);
      #2;
    end
    apb_access(1'b0, reg_status, 32'h0, rd, err);
    if (rd !== ((int'(r.k) - int'(r.k) % 64) << 1))
      report_mismatch("status at end", rd, (int'(r.k) - int'(r.k) % 64) << 1);
    if (mv_count != n_exp)
      report_mismatch("m_valid count", mv_count, n_exp);
    for (int i = 0; i < 3; i++)
    begin
      a                  = buf_base;
      a[cntr_width+1:2]  = probe[i][cntr_width-1:0];
      apb_access(1'b0, a, 32'h0, rd, err);
      if (rd !== {probe[i][15:0], ch_a_value(r, probe[i])})
        report_mismatch("buffer word", rd, {probe[i][15:0], ch_a_value(r, probe[i])});
    end
    close_test($sformatf("capture row %0d", idx));
  endtask

  // ##########################################################################
  // main sequence
  // ##########################################################################

  initial
  begin
    logic [apb_addr_width-1:0] addrs [4];
    logic [31:0]               vals [4];
    logic [31:0]               rd;
    logic                      err;
    void'($urandom(6));
    aresetn  = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    s_sample = '0;
    s_valid  = 1'b0;
    // pre_count, tot_count, level, falling, use_soft, k, spike.
    rows[0] = {10'd10, 10'd100, 16'sd0, 1'b0, 1'b0, 10'd40, 10'd0};
    rows[1] = {10'd20, 10'd150, 16'sd1000, 1'b0, 1'b0, 10'd70, 10'd0};
    rows[2] = {10'd30, 10'd200, -16'sd2000, 1'b1, 1'b0, 10'd130, 10'd25};
    rows[3] = {10'd5, 10'd80, 16'sd30000, 1'b0, 1'b1, 10'd100, 10'd0};
    rows[4] = {10'd0, 10'd63, 16'sd500, 1'b1, 1'b0, 10'd1, 10'd0};
    cycle_limit = 2000;
    for (int i = 0; i < num_rows; i++)
      cycle_limit += (expected_count(rows[i]) + 4) * 4 + 200;
    repeat (10) @(posedge aclk);
    #2;
    aresetn = 1'b1;
    @(posedge aclk);
    #2;

    apb_access(1'b0, reg_status, 32'h0, rd, err);
    if (rd !== 32'h0)
      report_mismatch("status after reset", rd, 32'h0);
    addrs = '{reg_ctrl, reg_pre, reg_tot, reg_level};
    vals  = '{32'h4, 32'h155, 32'h2aa, 32'h1234};
    for (int i = 0; i < 4; i++)
    begin
      apb_access(1'b1, addrs[i], vals[i], rd, err);
      apb_access(1'b0, addrs[i], 32'h0, rd, err);
      if (rd !== vals[i])
        report_mismatch("register readback", rd, vals[i]);
      if (err !== 1'b0)
        report_mismatch("pslverr", err, 1'b0);
    end
    apb_access(1'b0, 13'h020, 32'h0, rd, err);
    if (err !== 1'b1)
      report_mismatch("pslverr on unmapped read", err, 1'b1);
    apb_access(1'b1, 13'h040, 32'hffff, rd, err);
    if (err !== 1'b1)
      report_mismatch("pslverr on unmapped write", err, 1'b1);
    apb_access(1'b0, reg_pre, 32'h0, rd, err);
    if (rd !== 32'h155)
      report_mismatch("pre_count after unmapped write", rd, 32'h155);
    close_test("register access");

    for (int i = 0; i < num_rows; i++)
      run_capture(i);

    $display("summary: %0d tests, %0d passed, %0d failed", tests_run,
             tests_run - tests_failed, tests_failed);
    if (tests_failed == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

// File: src.f
src/osc_pkg.sv
src/osc_trigger.sv
src/osc_capture.sv
src/osc_ring_buffer.sv
src/osc_apb_regs.sv
src/osc_top.sv
verif/osc_tb.sv
